// File: flist.f
+incdir+logic
logic/switch_pkg.sv
logic/port_arbiter.sv
logic/frame_fsm.sv
logic/header_store.sv
logic/mac_table.sv
logic/credit_pool.sv
logic/switch_top.sv
sim/switch_asserts.sv
sim/switch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the switch testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module switch_tb -o switch_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/switch_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "=== PASS ===" <<< "$out"; then
	exit 0
fi
echo "simulation reported failure"
exit 1

// File: sim/switch_tb.sv
`timescale 1ns/1ps
`include "switch_macros.svh"

module switch_tb;
	import switch_pkg::*;

	localparam int np = `SW_PORTS;
	localparam int tmo = 4000;	// cycles per wait

	logic clk = 1'b0;
	logic rst_n;
	rx_desc_t [np-1:0] rx_desc;
	logic [np-1:0] rx_desc_empty;
	logic [np-1:0] rx_desc_rd;
	logic [np-1:0][`SW_DATA_W-1:0] rx_data;
	logic [np-1:0] rx_data_rd;
	logic [np-1:0] tx_credit;
	tx_beat_t tx;
	logic [31:0] lfsr = 32'h6d60a1e7;

	// receive FIFO contents per port
	logic [15:0] rxd [np][$];
	logic [7:0] rxb [np][$];

	// all frames built so far
	logic [7:0] fr_data [$];
	int fr_off [$];
	int fr_len [$];
	int fr_port [$];
	bit fr_err [$];
	int st [np][$];	// staged but not yet in a FIFO

	// reference model state
	bit m_valid [256];
	logic [47:0] m_tag [256];
	int m_port [256];
	int m_rr;
	int m_cred [np];
	int exp_f [$];
	logic [np-1:0] exp_map [$];

	// collected output frames
	logic [np-1:0] got_map [$];
	int got_len [$];
	logic [7:0] got_data [$];
	bit in_frame;
	logic [np-1:0] cur_map;
	int cur_len;
	bit auto_ret;
	logic [np-1:0] give;

	int errors;
	int tests;
	int failed;
	int err_at_start;

	switch_top uut (
		.clk(clk),
		.rst_n(rst_n),
		.rx_desc(rx_desc),
		.rx_desc_empty(rx_desc_empty),
		.rx_desc_rd(rx_desc_rd),
		.rx_data(rx_data),
		.rx_data_rd(rx_data_rd),
		.tx(tx),
		.tx_credit(tx_credit)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] rnd(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [47:0] rnd_mac();
		logic [47:0] m;
		m = {rnd(16), rnd(32)};
		return m;
	endfunction

	function automatic int fold(input logic [47:0] mac);
		logic [7:0] h;
		h = '0;
		for (int i = 0; i < 6; i++)
			h = h ^ mac[8*i +: 8];
		return int'(h);
	endfunction

	function automatic bit quiet();
		bit q;
		q = !uut.busy && !in_frame && !tx.dv;
		for (int p = 0; p < np; p++)
			q = q && rxd[p].size() == 0 && rxb[p].size() == 0;
		return q;
	endfunction

	task automatic compare(input string name, input logic [31:0] e, input logic [31:0] a);
		if (e !== a) begin
			$display("ERR %s expected %h actual %h", name, e, a);
			errors++;
		end
	endtask

	task automatic abort(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$finish;
	endtask

	// receive FIFO models with one cycle of data read latency
	always @(posedge clk) begin
		for (int p = 0; p < np; p++) begin
			if (rst_n && rx_desc_rd[p] && rxd[p].size() != 0)
				void'(rxd[p].pop_front());
			if (rst_n && rx_data_rd[p] && rxb[p].size() != 0)
				rx_data[p] <= rxb[p].pop_front();
			rx_desc_empty[p] <= rxd[p].size() == 0;
			rx_desc[p] <= (rxd[p].size() != 0) ? rx_desc_t'(rxd[p][0]) : '0;
		end
	end

	// output monitor and credit return
	always @(posedge clk) begin
		if (!rst_n) begin
			in_frame = 1'b0;
		end else if (tx.dv) begin
			if (tx.sof) begin
				if (in_frame)
					$display("start of frame seen inside a running frame");
				errors += in_frame;
				in_frame = 1'b1;
				cur_map = tx.port_map;
				cur_len = 0;
			end else if (!in_frame || tx.port_map != cur_map) begin
				$display("data beat without a start, or port map changed within a frame");
				errors++;
			end
			got_data.push_back(tx.data);
			cur_len++;
		end else if (in_frame) begin
			in_frame = 1'b0;
			got_map.push_back(cur_map);
			got_len.push_back(cur_len);
			if (auto_ret)
				give = give | cur_map;
		end
		for (int p = 0; p < np; p++)
			m_cred[p] += give[p];
		tx_credit <= give;
		give = '0;
	end

	task automatic add_frame(input int p, input logic [47:0] da, input logic [47:0] sa,
			input int len, input bit err);
		logic [7:0] b;
		fr_off.push_back(fr_data.size());
		for (int i = 0; i < len; i++) begin
			if (i < 6)
				b = da[47-8*i -: 8];
			else if (i < 12)
				b = sa[95-8*i -: 8];
			else
				b = rnd(8);
			fr_data.push_back(b);
		end
		fr_len.push_back(len);
		fr_port.push_back(p);
		fr_err.push_back(err);
		st[p].push_back(fr_len.size() - 1);
	endtask

	task automatic model_frame(input int f);
		logic [47:0] da;
		logic [47:0] sa;
		logic [np-1:0] map;
		int di;
		int si;
		int p;
		bit hit;
		p = fr_port[f];
		if (fr_err[f] || fr_len[f] < `SW_HDR_BYTES)
			return;
		for (int i = 0; i < 6; i++) begin
			da = {da[39:0], fr_data[fr_off[f] + i]};
			sa = {sa[39:0], fr_data[fr_off[f] + 6 + i]};
		end
		di = fold(da);
		si = fold(sa);
		hit = m_valid[di] && m_tag[di] == da;	// read before the learn
		if (da == '1 || !hit)
			map = ~(np'(1) << p);
		else if (m_port[di] == p)
			map = '0;
		else
			map = np'(1) << m_port[di];
		m_valid[si] = 1'b1;
		m_tag[si] = sa;
		m_port[si] = p;
		if (map != '0) begin
			exp_f.push_back(f);
			exp_map.push_back(map);
			for (int q = 0; q < np; q++)
				m_cred[q] -= map[q];	// one credit taken per destination
		end
	endtask

	// move staged frames into the FIFOs and model them in grant order
	task automatic go();
		int f;
		int p;
		bit found;
		@(posedge clk);
		for (int q = 0; q < np; q++) begin
			for (int k = 0; k < st[q].size(); k++) begin
				f = st[q][k];
				for (int i = 0; i < fr_len[f]; i++)
					rxb[q].push_back(fr_data[fr_off[f] + i]);
				rxd[q].push_back({fr_err[f], 4'b0, `SW_LEN_W'(fr_len[f])});
			end
		end
		found = 1'b1;
		while (found) begin
			found = 1'b0;
			for (int i = 0; i < np; i++) begin
				p = (m_rr + i) % np;
				if (!found && st[p].size() != 0) begin
					f = st[p].pop_front();
					m_rr = (p + 1) % np;
					model_frame(f);
					found = 1'b1;
				end
			end
		end
	endtask

	task automatic check_frames(input string name);
		int n;
		int off;
		int f;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!quiet() && n < tmo);
		if (!quiet()) begin
			abort({"timeout: switch never went idle in test ", name});
		end else begin
			compare({name, " frame count"}, exp_f.size(), got_map.size());
			off = 0;
			for (int i = 0; i < exp_f.size() && i < got_map.size(); i++) begin
				f = exp_f[i];
				compare({name, " port map"}, exp_map[i], got_map[i]);
				compare({name, " length"}, fr_len[f], got_len[i]);
				for (int k = 0; k < fr_len[f] && k < got_len[i]; k++)
					compare({name, " byte"}, fr_data[fr_off[f] + k], got_data[off + k]);
				off += got_len[i];
			end
			exp_f.delete();
			exp_map.delete();
			got_map.delete();
			got_len.delete();
			got_data.delete();
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != err_at_start) begin
			failed++;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: ok", name);
		end
		err_at_start = errors;
	endtask

	task automatic credit_test();
		int c [np];
		int fit;
		int n;
		bit ok;
		bit held;
		auto_ret = 1'b0;
		c = m_cred;
		for (int i = 0; i < 3; i++)
			add_frame(0, '1, rnd_mac(), 12 + rnd(4), 1'b0);
		go();
		fit = 0;
		ok = 1'b1;
		foreach (exp_map[i]) begin
			for (int p = 0; p < np; p++)
				ok = ok && (!exp_map[i][p] || c[p] > 0);
			if (ok) begin
				fit++;
				for (int p = 0; p < np; p++)
					c[p] -= exp_map[i][p];
			end
		end
		n = 0;
		held = 1'b0;
		while (!held && n < tmo) begin
			@(posedge clk);
			#1;
			n++;
			held = got_map.size() >= fit && uut.u_frame_fsm.state == WAIT_CREDIT;
		end
		if (!held) begin
			abort("timeout: frame without credits never held back");
		end else begin
			repeat (32) @(posedge clk);	// the waiting frame has to stay put
			#1;
			compare("credits frames before return", fit, got_map.size() + in_frame);
			give = 4'b1110;	// one credit back on ports 1 to 3
			check_frames("credits");
			repeat (2) begin
				@(posedge clk);
				#1;
				give = 4'b1110;
			end
			@(posedge clk);
			auto_ret = 1'b1;
			end_test("credits");
		end
	endtask

	initial begin
		logic [47:0] m;
		rst_n = 1'b0;
		rx_desc = '0;
		rx_desc_empty = '1;
		rx_data = '0;
		tx_credit = '0;
		give = '0;
		auto_ret = 1'b1;
		m_rr = 0;
		for (int p = 0; p < np; p++)
			m_cred[p] = `SW_CREDIT_INIT;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		add_frame(0, rnd_mac(), rnd_mac(), 12 + rnd(5), 1'b0);
		add_frame(3, rnd_mac(), rnd_mac(), 12 + rnd(5), 1'b0);
		go();
		check_frames("flood");
		end_test("flood");

		m = rnd_mac();
		add_frame(2, rnd_mac(), m, 14 + rnd(4), 1'b0);
		go();
		check_frames("learn");
		add_frame(1, m, rnd_mac(), 14 + rnd(4), 1'b0);
		go();
		check_frames("learn");
		add_frame(2, m, rnd_mac(), 14 + rnd(4), 1'b0);	// back to its own port
		go();
		check_frames("learn");
		end_test("learn");

		add_frame(3, rnd_mac(), '1, 14 + rnd(4), 1'b0);
		go();
		add_frame(1, '1, rnd_mac(), 14 + rnd(4), 1'b0);
		go();
		check_frames("broadcast");
		end_test("broadcast");

		add_frame(0, rnd_mac(), rnd_mac(), 20, 1'b1);
		add_frame(1, rnd_mac(), rnd_mac(), 1 + rnd(3), 1'b0);
		add_frame(2, rnd_mac(), rnd_mac(), 12 + rnd(5), 1'b0);
		add_frame(0, rnd_mac(), rnd_mac(), 12 + rnd(5), 1'b0);	// behind the error frame
		add_frame(1, rnd_mac(), rnd_mac(), 12 + rnd(5), 1'b0);	// behind the runt
		go();
		check_frames("drain");
		end_test("drain");

		for (int p = 0; p < np; p++) begin
			add_frame(p, rnd_mac(), rnd_mac(), 12 + rnd(5), 1'b0);
			add_frame(p, rnd_mac(), rnd_mac(), 12 + rnd(5), 1'b0);
		end
		go();
		check_frames("round robin");
		end_test("round robin");

		credit_test();

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: sim/switch_asserts.sv
`timescale 1ns/1ps
`include "switch_macros.svh"

module switch_asserts (
	input logic clk,
	input logic rst_n,
	input switch_pkg::tx_beat_t tx,
	input logic [`SW_PORTS-1:0] rx_data_rd
);
	import switch_pkg::*;

	// first beat of a frame is always a data beat
	sof_has_dv: assert property (@(posedge clk) disable iff (!rst_n)
		tx.sof |-> tx.dv)
		else $error("tx.sof seen without tx.dv");

	// a sent byte goes somewhere
	dv_has_ports: assert property (@(posedge clk) disable iff (!rst_n)
		tx.dv |-> (tx.port_map != '0))
		else $error("tx.dv seen with an empty port map");

	one_reader: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(rx_data_rd))
		else $error("more than one receive byte FIFO read at once");

endmodule

bind switch_top switch_asserts u_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.tx(tx),
	.rx_data_rd(rx_data_rd)
);

// File: logic/switch_top.sv
`timescale 1ns/1ps
`include "switch_macros.svh"

module switch_top (
	input  logic clk,
	input  logic rst_n,
	input  switch_pkg::rx_desc_t [`SW_PORTS-1:0] rx_desc,
	input  logic [`SW_PORTS-1:0] rx_desc_empty,
	output logic [`SW_PORTS-1:0] rx_desc_rd,
	input  logic [`SW_PORTS-1:0][`SW_DATA_W-1:0] rx_data,
	output logic [`SW_PORTS-1:0] rx_data_rd,
	output switch_pkg::tx_beat_t tx,
	input  logic [`SW_PORTS-1:0] tx_credit
);
	import switch_pkg::*;

	localparam int pw = $clog2(`SW_PORTS);

	// arbiter to frame controller
	logic desc_valid;
	rx_desc_t desc;
	logic [pw-1:0] src_port;
	logic desc_pop;
	logic data_rd;
	logic [`SW_DATA_W-1:0] data_byte;
	logic busy;

	logic hdr_capture;
	logic hdr_replay;
	logic [`SW_DATA_W-1:0] hdr_byte;
	mac_hdr_t hdr;

	logic lookup_req;
	logic lookup_hit;
	logic [pw-1:0] lookup_port;

	logic credit_ok;
	logic credit_take;
	logic [`SW_PORTS-1:0] dest_map;

	port_arbiter u_port_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.rx_desc(rx_desc),
		.rx_desc_empty(rx_desc_empty),
		.rx_desc_rd(rx_desc_rd),
		.rx_data(rx_data),
		.rx_data_rd(rx_data_rd),
		.busy(busy),
		.desc_pop(desc_pop),
		.data_rd(data_rd),
		.desc_valid(desc_valid),
		.desc(desc),
		.src_port(src_port),
		.data_byte(data_byte)
	);

	frame_fsm u_frame_fsm (
		.clk(clk),
		.rst_n(rst_n),
		.desc_valid(desc_valid),
		.desc(desc),
		.src_port(src_port),
		.desc_pop(desc_pop),
		.data_rd(data_rd),
		.data_byte(data_byte),
		.busy(busy),
		.hdr_capture(hdr_capture),
		.hdr_replay(hdr_replay),
		.hdr_byte(hdr_byte),
		.hdr(hdr),
		.lookup_req(lookup_req),
		.lookup_hit(lookup_hit),
		.lookup_port(lookup_port),
		.credit_ok(credit_ok),
		.credit_take(credit_take),
		.dest_map(dest_map),
		.tx(tx)
	);

	header_store u_header_store (
		.clk(clk),
		.capture(hdr_capture),
		.replay(hdr_replay),
		.byte_in(data_byte),
		.hdr(hdr),
		.byte_out(hdr_byte)
	);

	mac_table u_mac_table (
		.clk(clk),
		.rst_n(rst_n),
		.lookup_req(lookup_req),
		.hdr(hdr),
		.src_port(src_port),
		.lookup_hit(lookup_hit),
		.lookup_port(lookup_port)
	);

	credit_pool u_credit_pool (
		.clk(clk),
		.rst_n(rst_n),
		.dest_map(dest_map),
		.credit_take(credit_take),
		.tx_credit(tx_credit),
		.credit_ok(credit_ok)
	);

endmodule

// File: logic/credit_pool.sv
`timescale 1ns/1ps
`include "switch_macros.svh"

module credit_pool (
	input  logic clk,
	input  logic rst_n,
	input  logic [`SW_PORTS-1:0] dest_map,
	input  logic credit_take,
	input  logic [`SW_PORTS-1:0] tx_credit,
	output logic credit_ok
);
	localparam logic [`SW_CREDIT_W-1:0] cmax = '1;
	localparam logic [`SW_CREDIT_W-1:0] cinit = `SW_CREDIT_W'(`SW_CREDIT_INIT);

	logic [`SW_PORTS-1:0] has_credit;

	for (genvar p = 0; p < `SW_PORTS; p++) begin : g_port
		logic [`SW_CREDIT_W-1:0] credits;
		logic dec;

		assign has_credit[p] = credits != '0;
		assign dec = credit_take && dest_map[p] && has_credit[p];

		always_ff @(posedge clk) begin
			if (!rst_n)
				credits <= cinit;
			else if (tx_credit[p] && !dec && credits != cmax)
				credits <= credits + 1'b1;	// saturates at cmax
			else if (dec && !tx_credit[p])
				credits <= credits - 1'b1;
		end
	end

	// ports outside the map don't matter
	assign credit_ok = &(has_credit | ~dest_map);

endmodule

// File: logic/mac_table.sv
`timescale 1ns/1ps
`include "switch_macros.svh"

module mac_table (
	input  logic clk,
	input  logic rst_n,
	input  logic lookup_req,
	input  switch_pkg::mac_hdr_t hdr,
	input  logic [$clog2(`SW_PORTS)-1:0] src_port,
	output logic lookup_hit,
	output logic [$clog2(`SW_PORTS)-1:0] lookup_port
);
	localparam int pw = $clog2(`SW_PORTS);
	localparam int depth = 1 << `SW_TBL_AW;

	logic [depth-1:0] valid;
	logic [47:0] tag_mem [depth];
	logic [pw-1:0] port_mem [depth];
	logic [`SW_TBL_AW-1:0] da_idx;
	logic [`SW_TBL_AW-1:0] sa_idx;

	// xor of the six address bytes, index is one byte wide
	function automatic logic [`SW_TBL_AW-1:0] fold(input logic [47:0] mac);
		logic [`SW_TBL_AW-1:0] h;
		h = '0;
		for (int i = 0; i < 6; i++)
			h = h ^ mac[8*i +: 8];
		return h;
	endfunction

	assign da_idx = fold(hdr.da);
	assign sa_idx = fold(hdr.sa);

	// lookup reads the old entry, learn writes on the same edge
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;
			lookup_hit <= 1'b0;
		end else if (lookup_req) begin
			lookup_hit <= valid[da_idx] && (tag_mem[da_idx] == hdr.da);
			valid[sa_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_req) begin
			lookup_port <= port_mem[da_idx];
			tag_mem[sa_idx] <= hdr.sa;
			port_mem[sa_idx] <= src_port;
		end
	end

endmodule

// File: logic/header_store.sv
`timescale 1ns/1ps
`include "switch_macros.svh"

module header_store (
	input  logic clk,
	input  logic capture,
	input  logic replay,
	input  logic [`SW_DATA_W-1:0] byte_in,
	output switch_pkg::mac_hdr_t hdr,
	output logic [`SW_DATA_W-1:0] byte_out
);
	import switch_pkg::*;

	localparam int iw = $clog2(`SW_HDR_BYTES);

	// newest byte at index 0, so the first one ends up on top
	logic [`SW_HDR_BYTES-1:0][`SW_DATA_W-1:0] hbuf;
	logic [iw-1:0] idx;
	logic [iw-1:0] sel;

	always_ff @(posedge clk) begin
		if (capture) begin
			hbuf <= {hbuf[`SW_HDR_BYTES-2:0], byte_in};
			idx <= '0;	// every capture rewinds replay
		end else if (replay) begin
			idx <= idx + 1'b1;
		end
	end

	assign sel = iw'(`SW_HDR_BYTES - 1) - idx;
	assign byte_out = hbuf[sel];
	assign hdr = mac_hdr_t'(hbuf);

endmodule

// File: logic/frame_fsm.sv
`timescale 1ns/1ps
`include "switch_macros.svh"

module frame_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic desc_valid,
	input  switch_pkg::rx_desc_t desc,
	input  logic [$clog2(`SW_PORTS)-1:0] src_port,
	output logic desc_pop,
	output logic data_rd,
	input  logic [`SW_DATA_W-1:0] data_byte,
	output logic busy,
	output logic hdr_capture,
	output logic hdr_replay,
	input  logic [`SW_DATA_W-1:0] hdr_byte,
	input  switch_pkg::mac_hdr_t hdr,
	output logic lookup_req,
	input  logic lookup_hit,
	input  logic [$clog2(`SW_PORTS)-1:0] lookup_port,
	input  logic credit_ok,
	output logic credit_take,
	output logic [`SW_PORTS-1:0] dest_map,
	output switch_pkg::tx_beat_t tx
);
	import switch_pkg::*;

	localparam logic [`SW_LEN_W-1:0] hdr_len = `SW_LEN_W'(`SW_HDR_BYTES);
	localparam logic [`SW_PORTS-1:0] one_port = `SW_PORTS'(1);

	fsm_state_t state;
	logic [`SW_LEN_W-1:0] cnt;	// bytes read, or beats sent in EMIT
	logic [`SW_LEN_W-1:0] cnt_nx;
	logic [`SW_LEN_W-1:0] len_q;
	logic bad_q;
	logic rd_vld;	// data_byte holds a fresh byte
	logic bcast;
	logic [`SW_PORTS-1:0] src_bit;
	tx_beat_t beat;

	assign cnt_nx = cnt + 1'b1;
	assign busy = state != IDLE;
	assign desc_pop = state == POP;
	assign lookup_req = state == LOOKUP;
	assign hdr_capture = (state == HEAD) && rd_vld;
	assign hdr_replay = (state == EMIT) && (cnt < hdr_len);

	always_comb begin
		case (state)
			HEAD: data_rd = cnt < hdr_len;
			// body read runs one beat ahead of the output
			EMIT: data_rd = (cnt_nx >= hdr_len) && (cnt_nx < len_q);
			DRAIN: data_rd = cnt != len_q;
			default: data_rd = 1'b0;
		endcase
	end

	assign bcast = hdr.da == '1;
	assign src_bit = one_port << src_port;

	always_comb begin
		if (bcast || !lookup_hit)
			dest_map = ~src_bit;	// flood
		else if (lookup_port == src_port)
			dest_map = '0;
		else
			dest_map = one_port << lookup_port;
	end

	assign credit_take = (state == WAIT_CREDIT) && (dest_map != '0) && credit_ok;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			cnt <= '0;
			rd_vld <= 1'b0;
		end else begin
			rd_vld <= data_rd;
			case (state)
				IDLE: begin
					cnt <= '0;
					if (desc_valid)
						state <= POP;
				end
				POP: state <= bad_q ? DRAIN : HEAD;
				HEAD: begin
					if (data_rd)
						cnt <= cnt_nx;
					if (rd_vld && cnt == hdr_len)
						state <= LOOKUP;
				end
				LOOKUP: state <= WAIT_CREDIT;
				WAIT_CREDIT: begin
					if (dest_map == '0) begin
						state <= DRAIN;	// body still sits in the FIFO
					end else if (credit_ok) begin
						cnt <= '0;
						state <= EMIT;
					end
				end
				EMIT: begin
					cnt <= cnt_nx;
					if (cnt_nx == len_q)
						state <= IDLE;
				end
				DRAIN: begin
					if (cnt == len_q)
						state <= IDLE;
					else
						cnt <= cnt_nx;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// descriptor is only valid until the pop
	always_ff @(posedge clk) begin
		if (state == IDLE && desc_valid) begin
			len_q <= desc.len;
			bad_q <= desc.err || (desc.len < hdr_len);
		end
	end

	always_comb begin
		beat.sof = (state == EMIT) && (cnt == '0);
		beat.dv = state == EMIT;
		beat.port_map = dest_map;
		beat.data = (cnt < hdr_len) ? hdr_byte : data_byte;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			tx <= '0;
		else
			tx <= beat;
	end

endmodule

// File: logic/port_arbiter.sv
`timescale 1ns/1ps
`include "switch_macros.svh"

module port_arbiter (
	input  logic clk,
	input  logic rst_n,
	input  switch_pkg::rx_desc_t [`SW_PORTS-1:0] rx_desc,
	input  logic [`SW_PORTS-1:0] rx_desc_empty,
	output logic [`SW_PORTS-1:0] rx_desc_rd,
	input  logic [`SW_PORTS-1:0][`SW_DATA_W-1:0] rx_data,
	output logic [`SW_PORTS-1:0] rx_data_rd,
	input  logic busy,
	input  logic desc_pop,
	input  logic data_rd,
	output logic desc_valid,
	output switch_pkg::rx_desc_t desc,
	output logic [$clog2(`SW_PORTS)-1:0] src_port,
	output logic [`SW_DATA_W-1:0] data_byte
);
	localparam int pw = $clog2(`SW_PORTS);

	logic [pw-1:0] rr_ptr;	// first port to search
	logic [pw-1:0] grant_q;
	logic [pw-1:0] pick;
	logic [pw-1:0] idx;
	logic [pw-1:0] sel;
	logic found;

	// first non-empty port from rr_ptr on, wrapping
	always_comb begin
		pick = rr_ptr;
		found = 1'b0;
		for (int i = 0; i < `SW_PORTS; i++) begin
			idx = rr_ptr + pw'(i);
			if (!found && !rx_desc_empty[idx]) begin
				pick = idx;
				found = 1'b1;
			end
		end
	end

	assign desc_valid = !busy && found;
	assign sel = busy ? grant_q : pick;	// held grant once a frame is running
	assign desc = rx_desc[sel];
	assign src_port = sel;
	assign data_byte = rx_data[grant_q];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rr_ptr <= '0;
			grant_q <= '0;
		end else if (desc_valid) begin
			grant_q <= pick;
			rr_ptr <= pick + 1'b1;
		end
	end

	always_comb begin
		for (int p = 0; p < `SW_PORTS; p++) begin
			rx_desc_rd[p] = desc_pop && (grant_q == pw'(p));
			rx_data_rd[p] = data_rd && (grant_q == pw'(p));
		end
	end

endmodule

// File: logic/switch_pkg.sv
`include "switch_macros.svh"

package switch_pkg;

	// receive descriptor as written by the MAC
	typedef struct packed {
		logic err;
		logic [3:0] rsvd;
		logic [`SW_LEN_W-1:0] len;	// bytes incl. addresses
	} rx_desc_t;

	// address bytes in wire order, destination first
	typedef struct packed {
		logic [47:0] da;
		logic [47:0] sa;
	} mac_hdr_t;

	// one byte of the output stream
	typedef struct packed {
		logic sof;
		logic dv;
		logic [`SW_PORTS-1:0] port_map;
		logic [`SW_DATA_W-1:0] data;
	} tx_beat_t;

	typedef enum logic [2:0] {
		IDLE,
		POP,
		HEAD,
		LOOKUP,
		WAIT_CREDIT,
		EMIT,
		DRAIN
	} fsm_state_t;

endpackage

// File: logic/switch_macros.svh
`ifndef SWITCH_MACROS_SVH
`define SWITCH_MACROS_SVH

// port count and datapath widths
`define SW_PORTS 4
`define SW_DATA_W 8
`define SW_LEN_W 11

// destination and source MAC, in bytes
`define SW_HDR_BYTES 12

// address table, 256 entries
`define SW_TBL_AW 8

// egress frame credits
`define SW_CREDIT_INIT 2
`define SW_CREDIT_W 3

`endif
